// ==== rtl/commit_pkg.sv ====
`default_nettype none

package commit_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int COMMIT_WIDTH = 2;
    localparam int AREG_W       = 5;
    localparam int WORD_W       = 32;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [AREG_W-1:0] areg_t;

    // --------------------------------------------------
    // ROB head entry
    // --------------------------------------------------
    // memory side of one slot, resolved by the LSU before commit
    typedef struct packed {
        logic       is_load;
        logic       is_store;
        logic       uncached;
        logic       hit;
        // victim block chosen for refill is dirty
        logic       dirty;
        word_t      paddr;
        word_t      victim_addr;
        word_t      wdata;
        logic [3:0] strb;
    } mem_op_t;

    typedef struct packed {
        logic    valid;
        logic    w_reg;
        areg_t   w_areg;
        word_t   w_data;
        mem_op_t mem;
    } commit_slot_t;

    // one ARF write port
    typedef struct packed {
        logic  we;
        areg_t areg;
        word_t data;
    } arf_write_t;

endpackage

`default_nettype wire

// ==== rtl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // --------------------------------------------------
    // block geometry
    // --------------------------------------------------
    localparam int BLOCK_WORDS = 4;
    // byte offset inside one block
    localparam int BLOCK_OFS_W = 4;
    // beat counter, one wider than a word index
    localparam int PTR_W       = 3;

    // --------------------------------------------------
    // request types
    // --------------------------------------------------
    // data cache port, read data comes back one cycle later
    typedef struct packed {
        logic              valid;
        logic              write;
        commit_pkg::word_t addr;
        commit_pkg::word_t wdata;
        logic [3:0]        strb;
        // whole-word write of a refill
        logic              refill;
    } cache_req_t;

    // one bus beat
    typedef struct packed {
        commit_pkg::word_t addr;
        logic              write;
        commit_pkg::word_t wdata;
        logic [3:0]        strb;
    } bus_req_t;

    // --------------------------------------------------
    // load/store FSM
    // --------------------------------------------------
    typedef enum logic [2:0] {
        S_NORMAL,
        S_CACHE_RD,
        S_BUS_WB,
        S_BUS_RD,
        S_CACHE_WR,
        S_UNCACHED,
        S_DONE
    } ls_state_e;

    // which response the block buffer takes in
    typedef enum logic {
        SRC_CACHE,
        SRC_BUS
    } block_src_e;

endpackage

`default_nettype wire

// ==== rtl/commit_select.sv ====
`default_nettype none

module commit_select (
    input  commit_pkg::commit_slot_t [commit_pkg::COMMIT_WIDTH-1:0] slots_i,
    input  logic                                                    busy_i,
    input  logic                                                    done_i,
    input  commit_pkg::word_t                                       load_data_i,
    output logic                                                    start_o,
    output logic [1:0]                                              commit_request_o,
    output commit_pkg::arf_write_t [commit_pkg::COMMIT_WIDTH-1:0]   arf_wr_o
);
    import commit_pkg::*;

    logic [COMMIT_WIDTH-1:0] is_mem;
    // slot 0 present and the FSM idle
    logic                    free0;
    // slot 0 retires without the FSM
    logic                    fast_ok;

    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            is_mem[i] = slots_i[i].mem.is_load | slots_i[i].mem.is_store;
        end
    end

    assign free0   = slots_i[0].valid & ~busy_i;
    assign fast_ok = ~is_mem[0] | (slots_i[0].mem.hit & ~slots_i[0].mem.uncached);

    // miss or uncached op goes to the FSM instead
    assign start_o = free0 & ~fast_ok;

    // --------------------------------------------------
    // commit decision
    // --------------------------------------------------
    assign commit_request_o[0] = (free0 & fast_ok) | done_i;
    // dual commit only for two plain ALU-type slots
    assign commit_request_o[1] = free0 & slots_i[1].valid & ~is_mem[0] & ~is_mem[1];

    // --------------------------------------------------
    // ARF write ports
    // --------------------------------------------------
    always_comb begin
        arf_wr_o = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            arf_wr_o[i].we   = commit_request_o[i] & slots_i[i].w_reg;
            arf_wr_o[i].areg = slots_i[i].w_areg;
            arf_wr_o[i].data = slots_i[i].w_data;
        end
        // end of a miss or uncached access, loads take the fetched word
        if (done_i) begin
            arf_wr_o[0].we   = slots_i[0].w_reg & slots_i[0].mem.is_load;
            arf_wr_o[0].data = load_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/block_buffer.sv ====
`default_nettype none

module block_buffer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         clear_i,
    input  logic                         capture_i,
    input  mem_pkg::block_src_e          src_i,
    input  commit_pkg::word_t            cache_rdata_i,
    input  commit_pkg::word_t            bus_rdata_i,
    input  logic                         advance_i,
    input  logic [1:0]                   word_sel_i,
    output logic [mem_pkg::PTR_W-1:0]    ptr_o,
    output logic                         last_o,
    output commit_pkg::word_t            word_o,
    output commit_pkg::word_t            sel_word_o
);
    import commit_pkg::*;
    import mem_pkg::*;

    word_t            words [BLOCK_WORDS];
    logic [PTR_W-1:0] ptr_q;
    logic [1:0]       idx;

    assign idx = ptr_q[1:0];

    // beat pointer, clear wins over advance
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr_q <= '0;
        end else if (clear_i) begin
            ptr_q <= '0;
        end else if (advance_i) begin
            ptr_q <= ptr_q + 1'b1;
        end
    end

    // word store, written at the current beat
    always_ff @(posedge clk) begin
        if (capture_i) begin
            words[idx] <= (src_i == SRC_BUS) ? bus_rdata_i : cache_rdata_i;
        end
    end

    assign ptr_o      = ptr_q;
    assign last_o     = (ptr_q == PTR_W'(BLOCK_WORDS - 1));
    // writeback or refill data
    assign word_o     = words[idx];
    // load result
    assign sel_word_o = words[word_sel_i];

endmodule

`default_nettype wire

// ==== rtl/miss_fsm.sv ====
`default_nettype none

module miss_fsm (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start_i,
    input  logic                        commit_i,
    input  commit_pkg::mem_op_t         mem_i,
    output mem_pkg::cache_req_t         cache_req_o,
    output mem_pkg::bus_req_t           bus_req_o,
    output logic                        bus_req_valid_o,
    input  logic                        bus_req_ready_i,
    input  logic                        bus_resp_valid_i,
    input  commit_pkg::word_t           buf_word_i,
    input  logic [mem_pkg::PTR_W-1:0]   buf_ptr_i,
    input  logic                        buf_last_i,
    output logic                        buf_clear_o,
    output logic                        buf_capture_o,
    output mem_pkg::block_src_e         buf_src_o,
    output logic                        buf_advance_o,
    output logic [1:0]                  buf_sel_o,
    output logic                        busy_o,
    output logic                        done_o,
    output logic                        hit_store_o
);
    import commit_pkg::*;
    import mem_pkg::*;

    ls_state_e        state_q;
    ls_state_e        state_d;
    mem_op_t          mem_q;
    // bus beat accepted, response still outstanding
    logic             pend_q;
    // cache read sent last cycle, data arrives now
    logic             rd_pend_q;
    logic             rd_issue;
    logic [PTR_W-1:0] rd_idx;

    // word address of beat idx inside the block of base
    function automatic word_t beat_addr(
        input word_t                  base,
        input logic [BLOCK_OFS_W-3:0] idx
    );
        beat_addr = {base[WORD_W-1:BLOCK_OFS_W], idx, 2'b00};
    endfunction

    // next read runs one beat ahead of the capture pointer
    assign rd_idx = buf_ptr_i + PTR_W'(rd_pend_q);

    // hit store retiring in S_NORMAL
    assign hit_store_o = (state_q == S_NORMAL) & commit_i & mem_i.is_store;

    assign busy_o    = (state_q != S_NORMAL);
    assign done_o    = (state_q == S_DONE);
    // uncached word always sits in buffer word 0
    assign buf_sel_o = mem_q.uncached ? 2'b00 : mem_q.paddr[BLOCK_OFS_W-1:2];

    // --------------------------------------------------
    // next state and request generation
    // --------------------------------------------------
    always_comb begin
        state_d         = state_q;
        cache_req_o     = '0;
        bus_req_o       = '0;
        bus_req_valid_o = 1'b0;
        buf_clear_o     = 1'b0;
        buf_capture_o   = 1'b0;
        buf_src_o       = SRC_BUS;
        buf_advance_o   = 1'b0;
        rd_issue        = 1'b0;

        case (state_q)
            S_NORMAL: begin
                if (hit_store_o) begin
                    cache_req_o.valid = 1'b1;
                    cache_req_o.write = 1'b1;
                    cache_req_o.addr  = mem_i.paddr;
                    cache_req_o.wdata = mem_i.wdata;
                    cache_req_o.strb  = mem_i.strb;
                end
                if (start_i) begin
                    buf_clear_o = 1'b1;
                    if (mem_i.uncached) begin
                        state_d = S_UNCACHED;
                    end else if (mem_i.dirty) begin
                        state_d = S_CACHE_RD;
                    end else begin
                        state_d = S_BUS_RD;
                    end
                end
            end

            S_CACHE_RD: begin
                buf_src_o     = SRC_CACHE;
                buf_capture_o = rd_pend_q;
                buf_advance_o = rd_pend_q;
                if (rd_pend_q && buf_last_i) begin
                    buf_clear_o = 1'b1;
                    state_d     = S_BUS_WB;
                end else begin
                    rd_issue         = 1'b1;
                    cache_req_o.valid = 1'b1;
                    cache_req_o.addr  = beat_addr(mem_q.victim_addr, rd_idx[1:0]);
                end
            end

            S_BUS_WB: begin
                bus_req_valid_o = ~pend_q;
                bus_req_o.addr  = beat_addr(mem_q.victim_addr, buf_ptr_i[1:0]);
                bus_req_o.write = 1'b1;
                bus_req_o.wdata = buf_word_i;
                bus_req_o.strb  = '1;
                if (bus_resp_valid_i) begin
                    buf_advance_o = 1'b1;
                    if (buf_last_i) begin
                        buf_clear_o = 1'b1;
                        state_d     = S_BUS_RD;
                    end
                end
            end

            S_BUS_RD: begin
                bus_req_valid_o = ~pend_q;
                bus_req_o.addr  = beat_addr(mem_q.paddr, buf_ptr_i[1:0]);
                if (bus_resp_valid_i) begin
                    buf_capture_o = 1'b1;
                    buf_advance_o = 1'b1;
                    if (buf_last_i) begin
                        buf_clear_o = 1'b1;
                        state_d     = S_CACHE_WR;
                    end
                end
            end

            // one refill word per cycle
            S_CACHE_WR: begin
                cache_req_o.valid  = 1'b1;
                cache_req_o.write  = 1'b1;
                cache_req_o.refill = 1'b1;
                cache_req_o.addr   = beat_addr(mem_q.paddr, buf_ptr_i[1:0]);
                cache_req_o.wdata  = buf_word_i;
                cache_req_o.strb   = '1;
                buf_advance_o      = 1'b1;
                if (buf_last_i) begin
                    state_d = S_DONE;
                end
            end

            S_UNCACHED: begin
                bus_req_valid_o = ~pend_q;
                bus_req_o.addr  = mem_q.paddr;
                bus_req_o.write = mem_q.is_store;
                bus_req_o.wdata = mem_q.wdata;
                bus_req_o.strb  = mem_q.strb;
                if (bus_resp_valid_i) begin
                    buf_capture_o = 1'b1;
                    state_d       = S_DONE;
                end
            end

            S_DONE: begin
                // cached store merges into the refilled block
                if (mem_q.is_store && !mem_q.uncached) begin
                    cache_req_o.valid = 1'b1;
                    cache_req_o.write = 1'b1;
                    cache_req_o.addr  = mem_q.paddr;
                    cache_req_o.wdata = mem_q.wdata;
                    cache_req_o.strb  = mem_q.strb;
                end
                state_d = S_NORMAL;
            end

            default: begin
                state_d = S_NORMAL;
            end
        endcase
    end

    // --------------------------------------------------
    // state registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= S_NORMAL;
            pend_q    <= 1'b0;
            rd_pend_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            rd_pend_q <= rd_issue;
            if (bus_resp_valid_i) begin
                pend_q <= 1'b0;
            end else if (bus_req_valid_o && bus_req_ready_i) begin
                pend_q <= 1'b1;
            end
        end
    end

    // op held for the whole sequence
    always_ff @(posedge clk) begin
        if (start_i && state_q == S_NORMAL) begin
            mem_q <= mem_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/commit_unit.sv ====
`default_nettype none

module commit_unit (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  commit_pkg::commit_slot_t [commit_pkg::COMMIT_WIDTH-1:0] slots_i,
    output logic [1:0]                                              commit_request_o,
    output commit_pkg::arf_write_t [commit_pkg::COMMIT_WIDTH-1:0]   arf_wr_o,
    output mem_pkg::cache_req_t                                     cache_req_o,
    input  commit_pkg::word_t                                       cache_rdata_i,
    output mem_pkg::bus_req_t                                       bus_req_o,
    output logic                                                    bus_req_valid_o,
    input  logic                                                    bus_req_ready_i,
    input  logic                                                    bus_resp_valid_i,
    input  commit_pkg::word_t                                       bus_rdata_i
);
    import commit_pkg::*;
    import mem_pkg::*;

    logic             start;
    logic             busy;
    logic             done;
    word_t            load_data;
    word_t            buf_word;
    logic [PTR_W-1:0] buf_ptr;
    logic             buf_last;
    logic             buf_clear;
    logic             buf_capture;
    logic             buf_advance;
    block_src_e       buf_src;
    logic [1:0]       buf_sel;

    // --------------------------------------------------
    // commit decision and ARF ports
    // --------------------------------------------------
    commit_select u_select (
        .slots_i          (slots_i),
        .busy_i           (busy),
        .done_i           (done),
        .load_data_i      (load_data),
        .start_o          (start),
        .commit_request_o (commit_request_o),
        .arf_wr_o         (arf_wr_o)
    );

    // --------------------------------------------------
    // miss and uncached sequencing
    // --------------------------------------------------
    miss_fsm u_fsm (
        .clk              (clk),
        .rst_n            (rst_n),
        .start_i          (start),
        .commit_i         (commit_request_o[0]),
        .mem_i            (slots_i[0].mem),
        .cache_req_o      (cache_req_o),
        .bus_req_o        (bus_req_o),
        .bus_req_valid_o  (bus_req_valid_o),
        .bus_req_ready_i  (bus_req_ready_i),
        .bus_resp_valid_i (bus_resp_valid_i),
        .buf_word_i       (buf_word),
        .buf_ptr_i        (buf_ptr),
        .buf_last_i       (buf_last),
        .buf_clear_o      (buf_clear),
        .buf_capture_o    (buf_capture),
        .buf_src_o        (buf_src),
        .buf_advance_o    (buf_advance),
        .buf_sel_o        (buf_sel),
        .busy_o           (busy),
        .done_o           (done),
        .hit_store_o      ()
    );

    block_buffer u_buf (
        .clk           (clk),
        .rst_n         (rst_n),
        .clear_i       (buf_clear),
        .capture_i     (buf_capture),
        .src_i         (buf_src),
        .cache_rdata_i (cache_rdata_i),
        .bus_rdata_i   (bus_rdata_i),
        .advance_i     (buf_advance),
        .word_sel_i    (buf_sel),
        .ptr_o         (buf_ptr),
        .last_o        (buf_last),
        .word_o        (buf_word),
        .sel_word_o    (load_data)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb/commit_unit_assert.sv ====
`default_nettype none

module commit_unit_assert (
    input logic                clk,
    input logic                rst_n,
    input mem_pkg::bus_req_t   bus_req_o,
    input logic                bus_req_valid_o,
    input logic                bus_req_ready_i,
    input logic [1:0]          commit_request_o,
    input logic                busy
);
    timeunit 1ns;
    timeprecision 100ps;

    // --------------------------------------------------
    // bus handshake
    // --------------------------------------------------
    a_bus_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req_valid_o && !bus_req_ready_i |=> bus_req_valid_o && $stable(bus_req_o))
        else $error("bus request changed before it was accepted");

    a_bus_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> !bus_req_valid_o)
        else $error("bus request raised while the unit is idle");

    // slot 1 never retires past slot 0
    a_commit_order: assert property (@(posedge clk) disable iff (!rst_n)
        commit_request_o[1] |-> commit_request_o[0])
        else $error("slot 1 committed without slot 0");

endmodule

`default_nettype wire

// ==== tb/commit_unit_tb.sv ====
`default_nettype none

module commit_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import commit_pkg::*;
    import mem_pkg::*;

    localparam int      N_OPS     = 200;
    localparam int      MISS_LEN  = 20;
    localparam int      MAX_DELAY = 8;
    localparam longint  TIMEOUT   = longint'(N_OPS) * MISS_LEN * MAX_DELAY * 8;

    logic                                  clk;
    logic                                  rst_n;
    commit_slot_t [COMMIT_WIDTH-1:0]       slots_i = '0;
    logic [1:0]                            commit_request_o;
    arf_write_t [COMMIT_WIDTH-1:0]         arf_wr_o;
    cache_req_t                            cache_req_o;
    word_t                                 cache_rdata_i = '0;
    bus_req_t                              bus_req_o;
    logic                                  bus_req_valid_o;
    logic                                  bus_req_ready_i = 1'b0;
    logic                                  bus_resp_valid_i = 1'b0;
    word_t                                 bus_rdata_i = '0;

    // models driven by the DUT, references updated from the rules
    word_t       mem_model [word_t];
    word_t       cache_model [word_t];
    word_t       ref_mem [word_t];
    word_t       ref_cache [word_t];
    word_t       beat_addrs [$];
    word_t       exp_addrs [$];
    int unsigned resp_wait = 0;
    word_t       resp_data;
    // cache writes flagged as refill during the current op
    int unsigned refill_writes = 0;

    tb_clock u_clock (.clk_o(clk), .rst_n_o(rst_n));

    commit_unit dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .slots_i          (slots_i),
        .commit_request_o (commit_request_o),
        .arf_wr_o         (arf_wr_o),
        .cache_req_o      (cache_req_o),
        .cache_rdata_i    (cache_rdata_i),
        .bus_req_o        (bus_req_o),
        .bus_req_valid_o  (bus_req_valid_o),
        .bus_req_ready_i  (bus_req_ready_i),
        .bus_resp_valid_i (bus_resp_valid_i),
        .bus_rdata_i      (bus_rdata_i)
    );

    bind commit_unit commit_unit_assert u_assert (
        .clk              (clk),
        .rst_n            (rst_n),
        .bus_req_o        (bus_req_o),
        .bus_req_valid_o  (bus_req_valid_o),
        .bus_req_ready_i  (bus_req_ready_i),
        .commit_request_o (commit_request_o),
        .busy             (busy)
    );

    function automatic word_t merge_bytes(word_t old, word_t nw, logic [3:0] strb);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[b*8 +: 8] = nw[b*8 +: 8];
        end
        return res;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t got);
        if (exp !== got) fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, got));
    endtask

    task automatic check_request(input string name, input logic [1:0] exp, input logic [1:0] got);
        if (exp !== got) fail_run($sformatf("mismatch %s expected %b actual %b", name, exp, got));
    endtask

    task automatic check_arf(input string name, input arf_write_t exp, input arf_write_t got);
        // address and data only matter when the port writes
        if (exp.we !== got.we || (exp.we && exp !== got)) begin
            fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, got));
        end
    endtask

    // --------------------------------------------------
    // cache model, one-cycle read data
    // --------------------------------------------------
    always @(posedge clk) begin
        if (cache_req_o.valid) begin
            if (cache_req_o.write) begin
                if (cache_req_o.refill) begin
                    refill_writes++;
                end
                cache_model[cache_req_o.addr >> 2] = merge_bytes(
                    cache_model[cache_req_o.addr >> 2], cache_req_o.wdata, cache_req_o.strb);
            end else begin
                cache_rdata_i <= cache_model[cache_req_o.addr >> 2];
            end
        end
    end

    // --------------------------------------------------
    // bus memory model, random ready and response delays
    // --------------------------------------------------
    always @(posedge clk) begin
        bus_resp_valid_i <= 1'b0;
        bus_req_ready_i  <= rst_n && ($urandom % 3 != 0);
        if (bus_req_valid_o && bus_req_ready_i) begin
            beat_addrs.push_back(bus_req_o.addr);
            if (bus_req_o.write) begin
                mem_model[bus_req_o.addr >> 2] = merge_bytes(
                    mem_model[bus_req_o.addr >> 2], bus_req_o.wdata, bus_req_o.strb);
            end
            resp_data = mem_model[bus_req_o.addr >> 2];
            resp_wait = 1 + $urandom % 4;
        end else if (resp_wait != 0) begin
            resp_wait--;
            if (resp_wait == 0) begin
                bus_resp_valid_i <= 1'b1;
                bus_rdata_i      <= resp_data;
            end
        end
    end

    // refill of the block holding word wi, with an optional victim writeback
    task automatic ref_refill(input word_t wi, input logic dirty, input word_t vi);
        word_t blk;
        word_t vblk;
        blk  = wi & ~word_t'(3);
        vblk = vi & ~word_t'(3);
        if (dirty) begin
            for (int i = 0; i < BLOCK_WORDS; i++) begin
                ref_mem[vblk + i] = ref_cache[vblk + i];
                exp_addrs.push_back((vblk + i) << 2);
            end
        end
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            ref_cache[blk + i] = ref_mem[blk + i];
            exp_addrs.push_back((blk + i) << 2);
        end
    endtask

    task automatic do_op(input int n);
        commit_slot_t s0;
        commit_slot_t s1;
        arf_write_t   e0;
        arf_write_t   e1;
        logic [1:0]   er;
        int           kind;
        int           exp_refills;
        word_t        wi;
        word_t        exp_data;
        string        name;
        s0 = '0;
        s1 = '0;
        kind = $urandom % 6;
        s0.valid = 1'b1;
        s0.w_areg = areg_t'($urandom);
        s0.w_data = $urandom;
        s0.mem.paddr = word_t'(($urandom % 64) << 2);
        s0.mem.victim_addr = word_t'(($urandom % 64) << 2);
        s0.mem.wdata = $urandom;
        s0.mem.strb = 4'($urandom % 15 + 1);
        s1.valid = ($urandom % 4 != 0);
        s1.w_reg = $urandom % 2;
        s1.w_areg = areg_t'($urandom);
        s1.w_data = $urandom;
        s1.mem.is_load = ($urandom % 4 == 0);
        wi = s0.mem.paddr >> 2;
        s0.mem.is_load = (kind != 0) && ($urandom % 2 == 0);
        s0.mem.is_store = (kind != 0) && !s0.mem.is_load;
        s0.w_reg = s0.mem.is_store ? 1'b0 : 1'(($urandom % 4) != 0);
        s0.mem.hit = (kind == 1 || kind == 2);
        s0.mem.uncached = (kind == 3);
        s0.mem.dirty = (kind == 5);
        beat_addrs.delete();
        exp_addrs.delete();
        refill_writes = 0;
        exp_refills = (kind >= 4) ? BLOCK_WORDS : 0;
        name = $sformatf("op %0d kind %0d", n, kind);
        // miss and uncached loads return fetched data, not the slot's w_data
        exp_data = s0.w_data;
        case (kind)
            1, 2: begin
                if (s0.mem.is_store) begin
                    ref_cache[wi] = merge_bytes(ref_cache[wi], s0.mem.wdata, s0.mem.strb);
                end else begin
                    s0.w_data = ref_cache[wi];
                    exp_data  = s0.w_data;
                end
            end
            3: begin
                exp_addrs.push_back(s0.mem.paddr);
                if (s0.mem.is_store) begin
                    ref_mem[wi] = merge_bytes(ref_mem[wi], s0.mem.wdata, s0.mem.strb);
                end else begin
                    exp_data = ref_mem[wi];
                end
            end
            4, 5: begin
                ref_refill(wi, s0.mem.dirty, s0.mem.victim_addr >> 2);
                if (s0.mem.is_store) begin
                    ref_cache[wi] = merge_bytes(ref_cache[wi], s0.mem.wdata, s0.mem.strb);
                end else begin
                    exp_data = ref_cache[wi];
                end
            end
            default: ;
        endcase
        er = {(kind == 0) && s1.valid && !s1.mem.is_load, 1'b1};
        e0 = '{we: s0.w_reg, areg: s0.w_areg, data: exp_data};
        e1 = '{we: s1.w_reg & er[1], areg: s1.w_areg, data: s1.w_data};

        @(posedge clk);
        slots_i[0] <= s0;
        slots_i[1] <= s1;
        do @(negedge clk); while (!commit_request_o[0]);
        check_request({name, " commit"}, er, commit_request_o);
        check_arf({name, " arf0"}, e0, arf_wr_o[0]);
        check_arf({name, " arf1"}, e1, arf_wr_o[1]);
        @(posedge clk);
        slots_i <= '0;
        @(negedge clk);

        if (beat_addrs.size() != exp_addrs.size()) begin
            fail_run($sformatf("%s issued %0d bus beats where %0d were due",
                name, beat_addrs.size(), exp_addrs.size()));
        end
        if (refill_writes != exp_refills) begin
            fail_run($sformatf("%s made %0d refill cache writes where %0d were due",
                name, refill_writes, exp_refills));
        end
        foreach (exp_addrs[i]) check_word({name, " beat addr"}, exp_addrs[i], beat_addrs[i]);
        for (int i = 0; i < 64; i++) begin
            check_word({name, " memory"}, ref_mem[word_t'(i)], mem_model[word_t'(i)]);
            check_word({name, " cache"}, ref_cache[word_t'(i)], cache_model[word_t'(i)]);
        end
    endtask

    // --------------------------------------------------
    // main sequence and watchdog
    // --------------------------------------------------
    initial begin
        void'($urandom(70804));
        for (int i = 0; i < 64; i++) begin
            mem_model[word_t'(i)]   = word_t'(i * 32'h01010101) ^ 32'h5a5a_1234;
            cache_model[word_t'(i)] = ~word_t'(i * 32'h00010003) ^ 32'h0f0f_3c3c;
        end
        ref_mem   = mem_model;
        ref_cache = cache_model;
        do @(posedge clk); while (!rst_n);
        for (int n = 0; n < N_OPS; n++) do_op(n);
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        #(TIMEOUT);
        fail_run("watchdog expired before all operations committed");
    end

endmodule

`default_nettype wire

// ==== commit_unit.f ====
rtl/commit_pkg.sv
rtl/mem_pkg.sv
rtl/commit_select.sv
rtl/block_buffer.sv
rtl/miss_fsm.sv
rtl/commit_unit.sv
tb/tb_clock.sv
tb/commit_unit_assert.sv
tb/commit_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= commit_unit_tb
FILELIST  ?= commit_unit.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
